// ==== Makefile ====
SIM      = verilator
TOP      = cpuTb
FILELIST = sources.f
FLAGS    = --binary --timing --assert -j 0
OBJDIR   = obj_dir
LOG      = sim.log
PASS     = Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== bench/clockGen.sv ====
`timescale 1ns/1ns
`default_nettype none

module clockGen #(
   parameter int PERIOD       = 100,
   parameter int RESET_CYCLES = 4
) (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // Held over the first rising edges and dropped on a falling edge.
   initial begin
      rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
   end

endmodule

`default_nettype wire

// ==== bench/cpuCore_asserts.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpuCoreAsserts (
   input wire               clk,
   input wire               rst,
   input wire isaPkg::wordT pc,
   input wire               wbValid,
   input wire               halted,
   input wire               stall,
   input wire               branchD,
   input wire               takeRedirect
);

   // Halted is sticky, only a reset clears it.
   haltedSticky: assert property (@(posedge clk) $fell(halted) |-> $past(rst))
      else $error("halted fell without a reset");

   // A data stall holds the PC.
   stallHoldsPc: assert property (@(posedge clk) disable iff (rst)
      (stall && !branchD && !takeRedirect) |=> $stable(pc))
      else $error("pc moved after a data stall bubble");

   // Nothing leaves W right after a reset.
   quietAfterReset: assert property (@(posedge clk) rst |=> !wbValid)
      else $error("wb.valid high in the cycle after reset");

endmodule

bind cpuCore cpuCoreAsserts cpuCoreAsserts_inst (
   .clk          (clk),
   .rst          (rst),
   .pc           (pc),
   .wbValid      (wb.valid),
   .halted       (halted),
   .stall        (fetch_inst.stall),
   .branchD      (fetch_inst.branchD),
   .takeRedirect (fetch_inst.takeRedirect)
);

`default_nettype wire

// ==== bench/cpuTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpuTb;
   import isaPkg::*;
   import pipePkg::*;

   localparam int NUM_TESTS   = 6;
   localparam int PROG_LEN    = 40;
   localparam int MEM_WORDS   = 64;
   localparam int CLK_PERIOD  = 100;
   localparam int WATCHDOG_NS = NUM_TESTS * PROG_LEN * 4 * CLK_PERIOD + 20000;

   typedef enum int {K_INDEP, K_CHAIN, K_BRANCH, K_HALT, K_MIXED} progKindT;

   logic        clk;
   logic        powerOnRst;
   logic        testRst;
   logic        rst;
   instrT       instr;
   wordT        pc;
   wbT          wb;
   logic        halted;

   instrT       prog [MEM_WORDS];
   wbT          expQ [$];
   wordT        expPc;
   logic [31:0] rngState;
   regIdxT      recent [3];
   regIdxT      lastDest;
   int          errors;
   int          passed;
   int          failed;

   assign rst = powerOnRst || testRst;

   clockGen clockGen_inst (.clk(clk), .rst(powerOnRst));

   cpuCore cpuCore_inst (
      .clk    (clk),
      .rst    (rst),
      .instr  (instr),
      .pc     (pc),
      .wb     (wb),
      .halted (halted)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic int randBelow(input int n);
      rngState = xorshift32(rngState);
      return int'(rngState % n);
   endfunction

   function automatic regIdxT randReg();
      return regIdxT'(randBelow(NUM_REGS));
   endfunction

   function automatic instrT encodeR(input opcodeT op, input regIdxT src1, src2, dst);
      instrT w;
      w.r = '{opcode: op, rs: src1, rt: src2, rd: dst, unused: 2'b00};
      return w;
   endfunction

   function automatic instrT encodeI(input opcodeT op, input regIdxT src1, dst, input int imm);
      instrT w;
      w.i = '{opcode: op, rs: src1, rd: dst, imm: 5'(imm)};
      return w;
   endfunction

   function automatic wordT sext5(input logic [4:0] v);
      return {{11{v[4]}}, v};
   endfunction

   // Last three destinations for programs without close reuse.
   function automatic void pushDest(input regIdxT d);
      recent[2] = recent[1];
      recent[1] = recent[0];
      recent[0] = d;
      lastDest  = d;
   endfunction

   function automatic regIdxT freshReg();
      regIdxT r;
      do begin
         r = randReg();
      end while (r == recent[0] || r == recent[1] || r == recent[2]);
      return r;
   endfunction

   function automatic instrT genSlot(input progKindT kind, input int idx, input int haltIdx);
      int     pick;
      int     reach;
      regIdxT s1;
      regIdxT s2;
      regIdxT d;
      instrT  w;
      pick  = randBelow(10);
      // Branches only jump forward and never past the HALT.
      reach = (haltIdx - idx < 16) ? haltIdx - idx : 16;
      s1    = randReg();
      s2    = randReg();
      d     = randReg();
      w     = encodeR(OP_NOP, s1, s2, d);
      case (kind)
         K_INDEP: begin
            if (idx < NUM_REGS) begin
               d = regIdxT'(idx);
               w = encodeI(OP_ADDI, d, d, randBelow(32));
            end else begin
               s1 = freshReg();
               s2 = freshReg();
               d  = freshReg();
               if (pick < 4) w = encodeR(OP_ADD, s1, s2, d);
               else if (pick < 7) w = encodeR(OP_SUB, s1, s2, d);
               else w = encodeR(OP_AND, s1, s2, d);
            end
         end
         K_CHAIN: begin
            if (pick < 8) s1 = lastDest;
            if (pick > 3) s2 = lastDest;
            if (pick % 2 == 0) w = encodeI(OP_ADDI, s1, d, randBelow(32));
            else w = encodeR(OP_ADD, s1, s2, d);
         end
         K_BRANCH: begin
            if (pick < 3) w = encodeI(OP_BEQZ, s1, 3'd0, randBelow(reach));
            else if (pick < 5) w = encodeR(OP_SUB, s1, s1, d);
            else if (pick < 8) w = encodeI(OP_ADDI, s1, d, randBelow(32));
            else w = encodeR(OP_ADD, s1, s2, d);
         end
         K_HALT: begin
            if (pick < 3) w = encodeI(OP_ADDI, lastDest, d, randBelow(32));
            else if (pick < 5) w = encodeR(OP_ADD, lastDest, s2, d);
            else if (pick < 7) w = encodeR(OP_SUB, s1, s2, d);
            else if (pick < 9) w = encodeR(OP_AND, s1, lastDest, d);
         end
         default: begin
            if (pick < 1) w = encodeR(OP_NOP, s1, s2, d);
            else if (pick < 3) w = encodeI(OP_BEQZ, lastDest, 3'd0, randBelow(reach));
            else if (pick < 4) w = encodeR(OP_AND, s1, s2, d);
            else if (pick < 5) w = encodeR(OP_SUB, s1, s2, d);
            else if (pick < 7) w = encodeR(OP_ADD, lastDest, s2, d);
            else w = encodeI(OP_ADDI, lastDest, d, randBelow(32));
         end
      endcase
      pushDest(d);
      return w;
   endfunction

   task automatic genProgram(input progKindT kind);
      int haltIdx;
      haltIdx  = (kind == K_HALT) ? 12 + randBelow(16) : PROG_LEN - 1;
      lastDest = 3'd0;
      for (int k = 0; k < 3; k++) begin
         recent[k] = 3'd0;
      end
      // Words past the HALT are dead-code writers in the halt test.
      for (int i = 0; i < MEM_WORDS; i++) begin
         if (i < haltIdx) prog[i] = genSlot(kind, i, haltIdx);
         else if (i == haltIdx || kind != K_HALT) prog[i] = encodeR(OP_HALT, 3'd0, 3'd0, 3'd0);
         else prog[i] = encodeI(OP_ADDI, randReg(), randReg(), randBelow(32));
      end
   endtask

   // Sequential ISA model with one instruction per step.
   task automatic runModel();
      wordT  regs [NUM_REGS];
      wordT  p;
      instrT w;
      wbT    e;
      logic  done;
      for (int k = 0; k < NUM_REGS; k++) begin
         regs[k] = '0;
      end
      expQ.delete();
      p    = '0;
      done = 1'b0;
      while (!done) begin
         w = prog[p[6:1]];
         e = '0;
         e.valid       = 1'b1;
         e.dest.wrt    = 1'b1;
         e.dest.regIdx = w.r.rd;
         case (w.r.opcode)
            OP_ADD: e.data = regs[w.r.rs] + regs[w.r.rt];
            OP_SUB: e.data = regs[w.r.rs] - regs[w.r.rt];
            OP_AND: e.data = regs[w.r.rs] & regs[w.r.rt];
            OP_ADDI: begin
               e.dest.regIdx = w.i.rd;
               e.data        = regs[w.i.rs] + sext5(w.i.imm);
            end
            default: e.valid = 1'b0;
         endcase
         if (e.valid) begin
            regs[e.dest.regIdx] = e.data;
            expQ.push_back(e);
         end
         if (w.r.opcode == OP_BEQZ && regs[w.i.rs] == '0) begin
            p = p + wordT'(PC_STEP) + (sext5(w.i.imm) << 1);
         end else begin
            p = p + wordT'(PC_STEP);
         end
         if (w.r.opcode == OP_HALT) begin
            done  = 1'b1;
            expPc = p;
         end
      end
   endtask

   task automatic checkWb(input string name, input wbT exp, input wbT act);
      if (act !== exp) begin
         errors++;
         $display("FAILED %s wb: expected %0b/%0b/r%0d/%h/%0b, actual %0b/%0b/r%0d/%h/%0b",
                  name, exp.valid, exp.dest.wrt, exp.dest.regIdx, exp.data, exp.halt,
                  act.valid, act.dest.wrt, act.dest.regIdx, act.data, act.halt);
      end
   endtask

   task automatic checkPc(input string name, input wordT exp, input wordT act);
      if (act !== exp) begin
         errors++;
         $display("FAILED %s pc: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic checkFlag(input string name, input string what, input logic exp,
                            input logic act);
      if (act !== exp) begin
         errors++;
         $display("FAILED %s %s: expected %b, actual %b", name, what, exp, act);
      end
   endtask

   task automatic checkPulse(input string name, inout int seen);
      wbT exp;
      if (wb.valid) begin
         if (expQ.size() == 0) begin
            errors++;
            $display("%s: writeback to r%0d when none was expected", name, wb.dest.regIdx);
         end else begin
            exp = expQ.pop_front();
            checkWb(name, exp, wb);
         end
         seen++;
      end
   endtask

   task automatic applyReset();
      testRst = 1'b1;
      repeat (4) begin
         @(negedge clk);
         instr = prog[pc[6:1]];
      end
      testRst = 1'b0;
   endtask

   task automatic reportTest(input string name, input int startErrors, input int seen);
      if (errors == startErrors) begin
         passed++;
         $display("test %s: pass, %0d writebacks", name, seen);
      end else begin
         failed++;
         $display("test %s: fail, %0d errors", name, errors - startErrors);
      end
   endtask

   task automatic resetTest();
      int startErrors;
      startErrors = errors;
      for (int i = 0; i < MEM_WORDS; i++) begin
         prog[i] = encodeR(OP_HALT, 3'd0, 3'd0, 3'd0);
      end
      // Get halted high first so the reset has something to clear.
      applyReset();
      while (!halted) begin
         @(negedge clk);
         instr = prog[pc[6:1]];
      end
      applyReset();
      checkFlag("reset", "wb.valid", 1'b0, wb.valid);
      checkFlag("reset", "halted", 1'b0, halted);
      checkPc("reset", '0, pc);
      reportTest("reset", startErrors, 0);
   endtask

   task automatic runTest(input string name, input progKindT kind);
      int startErrors;
      int seen;
      startErrors = errors;
      seen        = 0;
      genProgram(kind);
      runModel();
      applyReset();
      while (!halted) begin
         @(negedge clk);
         instr = prog[pc[6:1]];
         checkPulse(name, seen);
      end
      // HALT sits in W in the cycle halted rises.
      checkFlag(name, "wb.halt", 1'b1, wb.halt);
      // Nothing may write in the cycles after HALT.
      repeat (8) begin
         @(negedge clk);
         instr = prog[pc[6:1]];
         checkPulse(name, seen);
         checkFlag(name, "halted", 1'b1, halted);
         checkFlag(name, "wb.halt", 1'b0, wb.halt);
      end
      if (expQ.size() != 0) begin
         errors++;
         $display("%s: %0d expected writebacks never appeared", name, expQ.size());
      end
      checkPc(name, expPc, pc);
      reportTest(name, startErrors, seen);
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog: the run did not finish within %0d ns", WATCHDOG_NS);
      $display("Result: FAILED");
      $finish;
   end

   initial begin
      rngState = 32'd48259;
      errors   = 0;
      passed   = 0;
      failed   = 0;
      testRst  = 1'b0;
      instr    = encodeR(OP_HALT, 3'd0, 3'd0, 3'd0);
      @(negedge clk);
      resetTest();
      runTest("indep", K_INDEP);
      runTest("chain", K_CHAIN);
      runTest("branch", K_BRANCH);
      runTest("halt", K_HALT);
      runTest("mixed", K_MIXED);
      $display("%0d tests passed, %0d failed, %0d check errors", passed, failed, errors);
      if (failed == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== sources.f ====
verilog/isaPkg.sv
verilog/pipePkg.sv
verilog/hazardDetect.sv
verilog/fetch.sv
verilog/decode.sv
verilog/execute.sv
verilog/cpuCore.sv
bench/clockGen.sv
bench/cpuCore_asserts.sv
bench/cpuTb.sv

// ==== verilog/cpuCore.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpuCore (
   input  wire                clk,
   input  wire                rst,
   input  wire isaPkg::instrT instr,
   output isaPkg::wordT       pc,
   output pipePkg::wbT        wb,
   output logic               halted
);
   import pipePkg::*;

   fetchT    toDecode;
   decodeT   toExecute;
   redirectT redirect;

   fetch fetch_inst (
      .clk      (clk),
      .rst      (rst),
      .instr    (instr),
      .destX    (toExecute.dest),
      .branchX  (toExecute.isBranch),
      .redirect (redirect),
      .pc       (pc),
      .toDecode (toDecode)
   );

   decode decode_inst (
      .clk       (clk),
      .rst       (rst),
      .fromFetch (toDecode),
      .wb        (wb),
      .toExecute (toExecute)
   );

   execute execute_inst (
      .clk        (clk),
      .rst        (rst),
      .fromDecode (toExecute),
      .redirect   (redirect),
      .wb         (wb),
      .halted     (halted)
   );

endmodule

`default_nettype wire

// ==== verilog/decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode (
   input  wire                 clk,
   input  wire                 rst,
   input  wire pipePkg::fetchT fromFetch,
   input  wire pipePkg::wbT    wb,
   output pipePkg::decodeT     toExecute
);
   import isaPkg::*;
   import pipePkg::*;

   wordT   regFile [NUM_REGS];
   opcodeT op;
   logic   immFmt;
   regIdxT rs;
   regIdxT rt;
   wordT   a;
   wordT   b;
   wordT   imm;
   logic   wbWrite;

   assign op     = fromFetch.instr.r.opcode;
   assign immFmt = (op == OP_ADDI) || (op == OP_BEQZ);

   // Pick the view that matches the format.
   assign rs  = fromFetch.instr.r.rs;
   assign rt  = fromFetch.instr.r.rt;
   assign imm = immFmt ? {{11{fromFetch.instr.i.imm[4]}}, fromFetch.instr.i.imm} : '0;

   assign wbWrite = wb.valid && wb.dest.wrt;

   // Write-through from W.
   assign a = (wbWrite && wb.dest.regIdx == rs) ? wb.data : regFile[rs];
   assign b = immFmt ? '0 :
              (wbWrite && wb.dest.regIdx == rt) ? wb.data : regFile[rt];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regFile[i] <= '0;
         end
      end else if (wbWrite) begin
         regFile[wb.dest.regIdx] <= wb.data;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         toExecute <= DECODE_BUBBLE;
      end else begin
         toExecute.valid    <= fromFetch.valid;
         toExecute.op       <= op;
         toExecute.dest     <= destOf(fromFetch.valid, fromFetch.instr);
         toExecute.a        <= a;
         toExecute.b        <= b;
         toExecute.imm      <= imm;
         toExecute.incPC    <= fromFetch.incPC;
         toExecute.isBranch <= fromFetch.valid && (op == OP_BEQZ);
         toExecute.isHalt   <= fromFetch.valid && (op == OP_HALT);
      end
   end

endmodule

`default_nettype wire

// ==== verilog/execute.sv ====
`timescale 1ns/1ns
`default_nettype none

module execute (
   input  wire                  clk,
   input  wire                  rst,
   input  wire pipePkg::decodeT fromDecode,
   output pipePkg::redirectT    redirect,
   output pipePkg::wbT          wb,
   output logic                 halted
);
   import isaPkg::*;
   import pipePkg::*;

   wordT result;
   logic haltNow;

   always_comb begin
      case (fromDecode.op)
         OP_ADD:  result = fromDecode.a + fromDecode.b;
         OP_SUB:  result = fromDecode.a - fromDecode.b;
         OP_AND:  result = fromDecode.a & fromDecode.b;
         OP_ADDI: result = fromDecode.a + fromDecode.imm;
         default: result = '0;
      endcase
   end

   // BEQZ taken when rs is zero, offset counts instructions.
   always_comb begin
      redirect.valid  = fromDecode.valid && fromDecode.isBranch && (fromDecode.a == '0);
      redirect.target = fromDecode.incPC + wordT'(fromDecode.imm * PC_STEP);
   end

   assign haltNow = fromDecode.valid && fromDecode.isHalt;

   always_ff @(posedge clk) begin
      if (rst) begin
         wb     <= WB_IDLE;
         halted <= 1'b0;
      end else begin
         wb.valid <= fromDecode.valid && fromDecode.dest.wrt;
         wb.dest  <= fromDecode.dest;
         wb.data  <= result;
         wb.halt  <= haltNow;
         // Sticky until reset.
         halted   <= halted || haltNow;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/fetch.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch (
   input  wire                   clk,
   input  wire                   rst,
   input  wire isaPkg::instrT    instr,
   input  wire pipePkg::destT    destX,
   input  wire                   branchX,
   input  wire pipePkg::redirectT redirect,
   output isaPkg::wordT          pc,
   output pipePkg::fetchT        toDecode
);
   import isaPkg::*;
   import pipePkg::*;

   wordT incPC;
   destT destD;
   logic branchD;
   logic stall;
   logic haltSeen;
   logic isHalt;
   logic takeRedirect;

   assign incPC = pc + wordT'(PC_STEP);

   // What sits in D right now.
   assign destD   = destOf(toDecode.valid, toDecode.instr);
   assign branchD = toDecode.valid && (toDecode.instr.r.opcode == OP_BEQZ);

   assign takeRedirect = branchX && redirect.valid;
   assign isHalt       = (instr.r.opcode == OP_HALT);

   hazardDetect hazardDetect_inst (
      .fetched (instr),
      .destD   (destD),
      .destX   (destX),
      .branchD (branchD),
      .stall   (stall)
   );

   always_ff @(posedge clk) begin
      if (rst) begin
         pc       <= RESET_PC;
         toDecode <= FETCH_BUBBLE;
         haltSeen <= 1'b0;
      end else if (takeRedirect) begin
         // Taken branch, the word at pc is wrong path.
         pc       <= redirect.target;
         toDecode <= FETCH_BUBBLE;
      end else if (haltSeen || stall) begin
         toDecode <= FETCH_BUBBLE;
      end else begin
         pc             <= incPC;
         toDecode.valid <= 1'b1;
         toDecode.instr <= instr;
         toDecode.incPC <= incPC;
         haltSeen       <= isHalt;
      end
   end

endmodule

`default_nettype wire

// ==== verilog/hazardDetect.sv ====
`timescale 1ns/1ns
`default_nettype none

module hazardDetect (
   input  wire isaPkg::instrT fetched,
   input  wire pipePkg::destT destD,
   input  wire pipePkg::destT destX,
   input  wire                branchD,
   output logic               stall
);
   import isaPkg::*;

   logic   readsRs;
   logic   readsRt;
   regIdxT rs;
   regIdxT rt;
   logic   rawD;
   logic   rawX;

   // Which source fields the opcode really reads.
   always_comb begin
      readsRs = 1'b0;
      readsRt = 1'b0;
      case (fetched.r.opcode)
         OP_ADD, OP_SUB, OP_AND: begin
            readsRs = 1'b1;
            readsRt = 1'b1;
         end
         OP_ADDI, OP_BEQZ: begin
            readsRs = 1'b1;
         end
         default: begin
            readsRs = 1'b0;
         end
      endcase
   end

   assign rs = fetched.r.rs;
   assign rt = fetched.r.rt;

   assign rawD = destD.wrt && ((readsRs && destD.regIdx == rs) ||
                               (readsRt && destD.regIdx == rt));
   assign rawX = destX.wrt && ((readsRs && destX.regIdx == rs) ||
                               (readsRt && destX.regIdx == rt));

   // W needs no check, decode forwards it.
   assign stall = rawD || rawX || branchD;

endmodule

`default_nettype wire

// ==== verilog/isaPkg.sv ====
`default_nettype none

package isaPkg;

   localparam int PC_STEP  = 2;
   localparam int NUM_REGS = 8;

   typedef logic [15:0] wordT;
   typedef logic [2:0]  regIdxT;

   typedef enum logic [4:0] {
      OP_HALT = 5'b00000,
      OP_NOP  = 5'b00001,
      OP_ADDI = 5'b01000,
      OP_BEQZ = 5'b01100,
      OP_ADD  = 5'b11000,
      OP_SUB  = 5'b11001,
      OP_AND  = 5'b11010
   } opcodeT;

   // Three-register ALU format.
   typedef struct packed {
      opcodeT      opcode;
      regIdxT      rs;
      regIdxT      rt;
      regIdxT      rd;
      logic [1:0]  unused;
   } rFmtT;

   // Immediate format, imm is two's complement.
   typedef struct packed {
      opcodeT             opcode;
      regIdxT             rs;
      regIdxT             rd;
      logic signed [4:0]  imm;
   } iFmtT;

   // Opcode and rs sit at the same bits in both views.
   typedef union packed {
      rFmtT r;
      iFmtT i;
   } instrT;

endpackage

`default_nettype wire

// ==== verilog/pipePkg.sv ====
`default_nettype none

package pipePkg;

   typedef struct packed {
      logic            wrt;
      isaPkg::regIdxT  regIdx;
   } destT;

   typedef struct packed {
      logic           valid;
      isaPkg::instrT  instr;
      isaPkg::wordT   incPC;
   } fetchT;

   typedef struct packed {
      logic            valid;
      isaPkg::opcodeT  op;
      destT            dest;
      isaPkg::wordT    a;
      isaPkg::wordT    b;
      isaPkg::wordT    imm;
      isaPkg::wordT    incPC;
      logic            isBranch;
      logic            isHalt;
   } decodeT;

   typedef struct packed {
      logic          valid;
      isaPkg::wordT  target;
   } redirectT;

   typedef struct packed {
      logic          valid;
      destT          dest;
      isaPkg::wordT  data;
      logic          halt;
   } wbT;

   localparam isaPkg::wordT RESET_PC = '0;
   localparam fetchT  FETCH_BUBBLE   = '0;
   localparam decodeT DECODE_BUBBLE  = '0;
   localparam wbT     WB_IDLE        = '0;

   // Destination register written by an instruction, if any.
   function automatic destT destOf(input logic valid, input isaPkg::instrT instr);
      destT d;
      d.wrt    = 1'b0;
      d.regIdx = instr.r.rd;
      case (instr.r.opcode)
         isaPkg::OP_ADD, isaPkg::OP_SUB, isaPkg::OP_AND: begin
            d.wrt = valid;
         end
         isaPkg::OP_ADDI: begin
            d.wrt    = valid;
            d.regIdx = instr.i.rd;
         end
         default: begin
            d.wrt = 1'b0;
         end
      endcase
      return d;
   endfunction

endpackage

`default_nettype wire
